// ==== common/sh_core_if.sv ====
`default_nettype none
`include "sh_core_params.svh"

// Decode to execute, through the forwarding units
interface sh_ex_if;
	import sh_core_pkg::*;

	dec_t                ex_dec;
	// Index 0 is Rn, index 1 is Rm
	logic [`SH_XLEN-1:0] ex_raw [`SH_OPERANDS];
	logic [`SH_XLEN-1:0] opnd   [`SH_OPERANDS];

	modport dec_mp (output ex_dec, output ex_raw, input opnd);
	modport fwd_mp (input ex_dec, input ex_raw, output opnd);
	modport exe_mp (input ex_dec, input opnd);
endinterface

// Results of the later stages, newest first
interface sh_result_if;
	logic                  ma_we;
	logic [`SH_REG_AW-1:0] ma_wn;
	logic [`SH_XLEN-1:0]   ma_res;
	logic                  wb_we;
	logic [`SH_REG_AW-1:0] wb_wn;
	logic [`SH_XLEN-1:0]   wb_res;
	logic                  wb2_we;
	logic [`SH_REG_AW-1:0] wb2_wn;
	logic [`SH_XLEN-1:0]   wb2_res;

	modport exe_mp (output ma_we, output ma_wn, output ma_res);
	modport mem_mp (input ma_we, input ma_wn, input ma_res,
		output wb_we, output wb_wn, output wb_res,
		output wb2_we, output wb2_wn, output wb2_res);
	modport fwd_mp (input ma_we, input ma_wn, input ma_res,
		input wb_we, input wb_wn, input wb_res,
		input wb2_we, input wb2_wn, input wb2_res);
endinterface

`default_nettype wire

// ==== common/sh_core_params.svh ====
`ifndef SH_CORE_PARAMS_SVH
`define SH_CORE_PARAMS_SVH

// Datapath and address width
`define SH_XLEN      32
`define SH_IR_W      16

// General register file
`define SH_REG_CNT   16
`define SH_REG_AW    4

// Source operands forwarded into execute
`define SH_OPERANDS  2

`define SH_NOP_IR    16'h0009

`endif

// ==== common/sh_core_pkg.sv ====
`default_nettype none
`include "sh_core_params.svh"

package sh_core_pkg;

	// Register-register and store layout
	typedef struct packed {
		logic [3:0]            op;
		logic [`SH_REG_AW-1:0] n;
		logic [`SH_REG_AW-1:0] m;
		logic [3:0]            fn;
	} ir_nm_t;

	// Immediate layout
	typedef struct packed {
		logic [3:0]            op;
		logic [`SH_REG_AW-1:0] n;
		logic [7:0]            imm;
	} ir_ni_t;

	typedef union packed {
		ir_nm_t nm;
		ir_ni_t ni;
	} instr_u;

	typedef enum logic [3:0] {
		ALU_PASS,
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_CMPEQ,
		ALU_SHLL,
		ALU_SHLR,
		ALU_MOVT
	} alu_op_e;

	// Same order as the low bits of the MOV.x Rm,@Rn codes
	typedef enum logic [1:0] {
		ST_BYTE,
		ST_WORD,
		ST_LONG
	} st_size_e;

	typedef struct packed {
		alu_op_e               alu;
		logic                  imm_sel;
		logic [`SH_XLEN-1:0]   imm;
		logic [`SH_REG_AW-1:0] rn;
		logic [`SH_REG_AW-1:0] rm;
		logic                  rn_rd;
		logic                  rm_rd;
		logic                  reg_we;
		logic                  t_we;
		logic                  st;
		st_size_e              st_sz;
	} dec_t;

endpackage

`default_nettype wire

// ==== decode/sh_decode.sv ====
`default_nettype none
`include "sh_core_params.svh"

module sh_decode (
	input  logic                  CLK,
	input  logic                  RST_N,
	input  logic                  CE,
	input  sh_core_pkg::instr_u   id_ir,
	input  logic                  bus_stall,
	input  logic                  front_hold,
	input  logic [`SH_XLEN-1:0]   rd_a,
	input  logic [`SH_XLEN-1:0]   rd_b,
	output logic [`SH_REG_AW-1:0] rn_a,
	output logic [`SH_REG_AW-1:0] rn_b,
	output logic                  ILI,
	sh_ex_if.dec_mp               ex
);
	import sh_core_pkg::*;

	dec_t dec;
	logic illegal;
	logic advance;

	assign rn_a    = id_ir.nm.n;
	assign rn_b    = id_ir.nm.m;
	assign advance = CE & ~bus_stall & ~front_hold;
	assign ILI     = illegal & advance;

	always_comb begin
		dec     = '0;
		illegal = 1'b0;
		dec.rn  = id_ir.nm.n;
		dec.rm  = id_ir.nm.m;
		dec.imm = {{(`SH_XLEN-8){id_ir.ni.imm[7]}}, id_ir.ni.imm};
		case (id_ir.nm.op)
			4'h0: begin
				if (id_ir.nm.m == 4'h2 && id_ir.nm.fn == 4'h9) begin
					dec.alu    = ALU_MOVT;
					dec.reg_we = 1'b1;
				end else if (id_ir != `SH_NOP_IR) begin
					illegal = 1'b1;
				end
			end
			4'h2: begin
				case (id_ir.nm.fn)
					4'h0, 4'h1, 4'h2: begin
						dec.st    = 1'b1;
						dec.st_sz = st_size_e'(id_ir.nm.fn[1:0]);
					end
					4'h9: dec.alu = ALU_AND;
					4'hA: dec.alu = ALU_XOR;
					4'hB: dec.alu = ALU_OR;
					default: illegal = 1'b1;
				endcase
				dec.rn_rd  = ~illegal;
				dec.rm_rd  = ~illegal;
				dec.reg_we = ~illegal & ~dec.st;
			end
			4'h3: begin
				case (id_ir.nm.fn)
					4'h0: dec.alu = ALU_CMPEQ;
					4'h8: dec.alu = ALU_SUB;
					4'hC: dec.alu = ALU_ADD;
					default: illegal = 1'b1;
				endcase
				dec.rn_rd  = ~illegal;
				dec.rm_rd  = ~illegal;
				dec.t_we   = ~illegal & (dec.alu == ALU_CMPEQ);
				dec.reg_we = ~illegal & (dec.alu != ALU_CMPEQ);
			end
			4'h4: begin
				if (id_ir.nm.m == 4'h0 && id_ir.nm.fn[3:1] == 3'b000) begin
					dec.alu    = id_ir.nm.fn[0] ? ALU_SHLR : ALU_SHLL;
					dec.rn_rd  = 1'b1;
					dec.reg_we = 1'b1;
					dec.t_we   = 1'b1;
				end else begin
					illegal = 1'b1;
				end
			end
			4'h6: begin
				if (id_ir.nm.fn == 4'h3) begin
					dec.rm_rd  = 1'b1;
					dec.reg_we = 1'b1;
				end else begin
					illegal = 1'b1;
				end
			end
			4'h7: begin
				dec.alu     = ALU_ADD;
				dec.imm_sel = 1'b1;
				dec.rn_rd   = 1'b1;
				dec.reg_we  = 1'b1;
			end
			4'hE: begin
				dec.imm_sel = 1'b1;
				dec.reg_we  = 1'b1;
			end
			default: illegal = 1'b1;
		endcase
	end

	// ****************************************
	// Decode to execute register
	// ****************************************
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			ex.ex_dec <= '0;
		end else if (advance) begin
			ex.ex_dec <= dec;
		end
	end

	always_ff @(posedge CLK) begin
		if (advance) begin
			ex.ex_raw[0] <= rd_a;
			ex.ex_raw[1] <= rd_b;
		end else if (CE && front_hold && !bus_stall) begin
			// A held operand keeps its producer's value once that leaves the trailing stage
			ex.ex_raw <= ex.opnd;
		end
	end

endmodule

`default_nettype wire

// ==== execute/sh_execute.sv ====
`default_nettype none
`include "sh_core_params.svh"

module sh_execute (
	input  logic                CLK,
	input  logic                RST_N,
	input  logic                CE,
	input  logic                bus_stall,
	input  logic                front_hold,
	sh_ex_if.exe_mp             ex,
	sh_result_if.exe_mp         res,
	output sh_core_pkg::dec_t   ma_dec,
	output logic [`SH_XLEN-1:0] ma_addr,
	output logic [`SH_XLEN-1:0] ma_wd
);
	import sh_core_pkg::*;

	logic                t_bit;
	logic [`SH_XLEN-1:0] alu_a;
	logic [`SH_XLEN-1:0] alu_b;
	logic [`SH_XLEN-1:0] alu_res;
	logic                alu_t;
	logic                advance;
	logic                bubble;

	assign advance = CE & ~bus_stall & ~front_hold;
	assign bubble  = CE & ~bus_stall & front_hold;

	// ****************************************
	// ALU
	// ****************************************
	assign alu_a = ex.opnd[0];
	assign alu_b = ex.ex_dec.imm_sel ? ex.ex_dec.imm : ex.opnd[1];

	always_comb begin
		alu_res = alu_b;
		alu_t   = t_bit;
		case (ex.ex_dec.alu)
			ALU_ADD:   alu_res = alu_a + alu_b;
			ALU_SUB:   alu_res = alu_a - alu_b;
			ALU_AND:   alu_res = alu_a & alu_b;
			ALU_OR:    alu_res = alu_a | alu_b;
			ALU_XOR:   alu_res = alu_a ^ alu_b;
			ALU_CMPEQ: alu_t = (alu_a == alu_b);
			ALU_SHLL: begin
				alu_res = {alu_a[`SH_XLEN-2:0], 1'b0};
				alu_t   = alu_a[`SH_XLEN-1];
			end
			ALU_SHLR: begin
				alu_res = {1'b0, alu_a[`SH_XLEN-1:1]};
				alu_t   = alu_a[0];
			end
			ALU_MOVT:  alu_res = {{(`SH_XLEN-1){1'b0}}, t_bit};
			default:   alu_res = alu_b;
		endcase
	end

	// ****************************************
	// Execute to memory access register
	// ****************************************
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			ma_dec <= '0;
			t_bit  <= 1'b0;
		end else if (advance) begin
			ma_dec <= ex.ex_dec;
			if (ex.ex_dec.t_we) begin
				t_bit <= alu_t;
			end
		end else if (bubble) begin
			ma_dec <= '0;
		end
	end

	// Address is Rn, store data is Rm
	always_ff @(posedge CLK) begin
		if (advance) begin
			res.ma_res <= alu_res;
			ma_addr    <= ex.opnd[0];
			ma_wd      <= ex.opnd[1];
		end
	end

	assign res.ma_we = ma_dec.reg_we;
	assign res.ma_wn = ma_dec.rn;

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tb_sh_core -f sh_core.f -Mdir obj_dir -o tb_sh_core
./obj_dir/tb_sh_core

// ==== sh_core.f ====
+incdir+common
common/sh_core_pkg.sv
common/sh_core_if.sv
source/sh_fetch_bus.sv
decode/sh_decode.sv
source/sh_regfile.sv
source/sh_operand_fwd.sv
execute/sh_execute.sv
source/sh_mem_access.sv
source/sh_core.sv
tests/tb_sh_core.sv

// ==== source/sh_core.sv ====
`default_nettype none
`include "sh_core_params.svh"

module sh_core (
	input  logic                CLK,
	input  logic                RST_N,
	input  logic                CE,
	output logic [`SH_XLEN-1:0] BUS_A,
	input  logic [`SH_XLEN-1:0] BUS_DI,
	output logic [`SH_XLEN-1:0] BUS_DO,
	output logic                BUS_WR,
	output logic [3:0]          BUS_BA,
	output logic                BUS_REQ,
	input  logic                BUS_WAIT,
	output logic                ILI
);
	import sh_core_pkg::*;

	instr_u                id_ir;
	logic                  bus_stall;
	logic                  front_hold;
	logic [`SH_REG_AW-1:0] rn_a;
	logic [`SH_REG_AW-1:0] rn_b;
	logic [`SH_XLEN-1:0]   rd_a;
	logic [`SH_XLEN-1:0]   rd_b;
	dec_t                  ma_dec;
	logic [`SH_XLEN-1:0]   ma_addr;
	logic [`SH_XLEN-1:0]   ma_wd;
	logic                  st_active;
	logic [`SH_XLEN-1:0]   st_addr;
	logic [`SH_XLEN-1:0]   st_wdata;
	logic [3:0]            st_ba;
	logic                  rf_we;
	logic [`SH_REG_AW-1:0] rf_wn;
	logic [`SH_XLEN-1:0]   rf_wd;

	sh_ex_if     ex_if ();
	sh_result_if res_if ();

	sh_fetch_bus u_fetch (
		.CLK(CLK), .RST_N(RST_N), .CE(CE),
		.BUS_DI(BUS_DI), .BUS_WAIT(BUS_WAIT),
		.st_active(st_active), .st_addr(st_addr), .st_wdata(st_wdata), .st_ba(st_ba),
		.BUS_A(BUS_A), .BUS_DO(BUS_DO), .BUS_WR(BUS_WR), .BUS_BA(BUS_BA), .BUS_REQ(BUS_REQ),
		.id_ir(id_ir), .bus_stall(bus_stall), .front_hold(front_hold)
	);

	sh_decode u_decode (
		.CLK(CLK), .RST_N(RST_N), .CE(CE),
		.id_ir(id_ir), .bus_stall(bus_stall), .front_hold(front_hold),
		.rd_a(rd_a), .rd_b(rd_b), .rn_a(rn_a), .rn_b(rn_b),
		.ILI(ILI), .ex(ex_if.dec_mp)
	);

	sh_regfile u_regfile (
		.CLK(CLK), .RST_N(RST_N), .CE(CE),
		.rn_a(rn_a), .rn_b(rn_b),
		.we(rf_we), .wn(rf_wn), .wd(rf_wd),
		.rd_a(rd_a), .rd_b(rd_b)
	);

	// One forwarding unit per source operand
	for (genvar i = 0; i < `SH_OPERANDS; i++) begin : g_fwd
		sh_operand_fwd #(.IDX(i)) u_fwd (
			.ex(ex_if.fwd_mp),
			.res(res_if.fwd_mp)
		);
	end

	sh_execute u_execute (
		.CLK(CLK), .RST_N(RST_N), .CE(CE),
		.bus_stall(bus_stall), .front_hold(front_hold),
		.ex(ex_if.exe_mp), .res(res_if.exe_mp),
		.ma_dec(ma_dec), .ma_addr(ma_addr), .ma_wd(ma_wd)
	);

	sh_mem_access u_mem (
		.CLK(CLK), .RST_N(RST_N), .CE(CE), .bus_stall(bus_stall),
		.ma_dec(ma_dec), .ma_addr(ma_addr), .ma_wd(ma_wd),
		.st_active(st_active), .st_addr(st_addr), .st_wdata(st_wdata), .st_ba(st_ba),
		.rf_we(rf_we), .rf_wn(rf_wn), .rf_wd(rf_wd),
		.res(res_if.mem_mp)
	);

endmodule

`default_nettype wire

// ==== source/sh_fetch_bus.sv ====
`default_nettype none
`include "sh_core_params.svh"

module sh_fetch_bus (
	input  logic                CLK,
	input  logic                RST_N,
	input  logic                CE,
	input  logic [`SH_XLEN-1:0] BUS_DI,
	input  logic                BUS_WAIT,
	input  logic                st_active,
	input  logic [`SH_XLEN-1:0] st_addr,
	input  logic [`SH_XLEN-1:0] st_wdata,
	input  logic [3:0]          st_ba,
	output logic [`SH_XLEN-1:0] BUS_A,
	output logic [`SH_XLEN-1:0] BUS_DO,
	output logic                BUS_WR,
	output logic [3:0]          BUS_BA,
	output logic                BUS_REQ,
	output sh_core_pkg::instr_u id_ir,
	output logic                bus_stall,
	output logic                front_hold
);
	logic [`SH_XLEN-1:0] pc;
	logic [`SH_IR_W-1:0] save_ir;
	logic                need_fetch;
	logic                advance;

	// Upper half needs a new word, lower half comes from the save
	assign need_fetch = ~pc[1];
	assign BUS_REQ    = st_active | need_fetch;
	assign bus_stall  = BUS_REQ & BUS_WAIT;
	assign front_hold = st_active & need_fetch;
	assign advance    = CE & ~bus_stall & ~front_hold;

	// Store in memory access wins the bus
	assign BUS_A  = st_active ? st_addr : {pc[`SH_XLEN-1:2], 2'b00};
	assign BUS_DO = st_wdata;
	assign BUS_WR = st_active;
	assign BUS_BA = st_active ? st_ba : 4'b1111;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			pc    <= '0;
			id_ir <= `SH_NOP_IR;
		end else if (advance) begin
			pc    <= pc + `SH_XLEN'(2);
			id_ir <= need_fetch ? BUS_DI[31:16] : save_ir;
		end
	end

	always_ff @(posedge CLK) begin
		if (advance && need_fetch) begin
			save_ir <= BUS_DI[15:0];
		end
	end

endmodule

`default_nettype wire

// ==== source/sh_mem_access.sv ====
`default_nettype none
`include "sh_core_params.svh"

module sh_mem_access (
	input  logic                  CLK,
	input  logic                  RST_N,
	input  logic                  CE,
	input  logic                  bus_stall,
	input  sh_core_pkg::dec_t     ma_dec,
	input  logic [`SH_XLEN-1:0]   ma_addr,
	input  logic [`SH_XLEN-1:0]   ma_wd,
	output logic                  st_active,
	output logic [`SH_XLEN-1:0]   st_addr,
	output logic [`SH_XLEN-1:0]   st_wdata,
	output logic [3:0]            st_ba,
	output logic                  rf_we,
	output logic [`SH_REG_AW-1:0] rf_wn,
	output logic [`SH_XLEN-1:0]   rf_wd,
	sh_result_if.mem_mp           res
);
	import sh_core_pkg::*;

	logic advance;

	assign advance   = CE & ~bus_stall;
	assign st_active = ma_dec.st;
	assign st_addr   = ma_addr;

	// Big-endian lanes, lane 3 is the top byte
	always_comb begin
		case (ma_dec.st_sz)
			ST_BYTE: begin
				st_wdata = {4{ma_wd[7:0]}};
				st_ba    = 4'b1000 >> ma_addr[1:0];
			end
			ST_WORD: begin
				st_wdata = {2{ma_wd[15:0]}};
				st_ba    = ma_addr[1] ? 4'b0011 : 4'b1100;
			end
			default: begin
				st_wdata = ma_wd;
				st_ba    = 4'b1111;
			end
		endcase
	end

	// ****************************************
	// Write-back and trailing stages
	// ****************************************
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			res.wb_we  <= 1'b0;
			res.wb_wn  <= '0;
			res.wb2_we <= 1'b0;
			res.wb2_wn <= '0;
		end else if (advance) begin
			res.wb_we  <= res.ma_we;
			res.wb_wn  <= res.ma_wn;
			res.wb2_we <= res.wb_we;
			res.wb2_wn <= res.wb_wn;
		end
	end

	always_ff @(posedge CLK) begin
		if (advance) begin
			res.wb_res  <= res.ma_res;
			res.wb2_res <= res.wb_res;
		end
	end

	assign rf_we = res.wb_we & ~bus_stall;
	assign rf_wn = res.wb_wn;
	assign rf_wd = res.wb_res;

endmodule

`default_nettype wire

// ==== source/sh_operand_fwd.sv ====
`default_nettype none
`include "sh_core_params.svh"

module sh_operand_fwd #(
	parameter int unsigned IDX = 0
) (
	sh_ex_if.fwd_mp     ex,
	sh_result_if.fwd_mp res
);
	logic [`SH_REG_AW-1:0] rn;
	logic                  rd;
	logic [`SH_XLEN-1:0]   val;

	// Operand 0 is Rn, operand 1 is Rm
	assign rn = (IDX == 0) ? ex.ex_dec.rn : ex.ex_dec.rm;
	assign rd = (IDX == 0) ? ex.ex_dec.rn_rd : ex.ex_dec.rm_rd;

	// Youngest producer first
	always_comb begin
		if (rd && res.ma_we && res.ma_wn == rn) begin
			val = res.ma_res;
		end else if (rd && res.wb_we && res.wb_wn == rn) begin
			val = res.wb_res;
		end else if (rd && res.wb2_we && res.wb2_wn == rn) begin
			val = res.wb2_res;
		end else begin
			val = ex.ex_raw[IDX];
		end
	end

	assign ex.opnd[IDX] = val;

endmodule

`default_nettype wire

// ==== source/sh_regfile.sv ====
`default_nettype none
`include "sh_core_params.svh"

module sh_regfile (
	input  logic                  CLK,
	input  logic                  RST_N,
	input  logic                  CE,
	input  logic [`SH_REG_AW-1:0] rn_a,
	input  logic [`SH_REG_AW-1:0] rn_b,
	input  logic                  we,
	input  logic [`SH_REG_AW-1:0] wn,
	input  logic [`SH_XLEN-1:0]   wd,
	output logic [`SH_XLEN-1:0]   rd_a,
	output logic [`SH_XLEN-1:0]   rd_b
);
	logic [`SH_XLEN-1:0] regs [`SH_REG_CNT];

	// Reads see the value before a same-cycle write
	assign rd_a = regs[rn_a];
	assign rd_b = regs[rn_b];

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			for (int i = 0; i < `SH_REG_CNT; i++) begin
				regs[i] <= '0;
			end
		end else if (CE && we) begin
			regs[wn] <= wd;
		end
	end

endmodule

`default_nettype wire

// ==== tests/tb_sh_core.sv ====
`default_nettype none
`include "sh_core_params.svh"

module tb_sh_core;

	localparam int CLK_HALF   = 50;
	localparam int DRIVE_DLY  = 10;
	localparam int PROG_MAX   = 256;
	localparam int BODY_LEN   = 184;
	localparam int CYC_PER_IR = 20;

	logic                CLK;
	logic                RST_N;
	logic                CE;
	logic [`SH_XLEN-1:0] BUS_A;
	logic [`SH_XLEN-1:0] BUS_DI;
	logic [`SH_XLEN-1:0] BUS_DO;
	logic                BUS_WR;
	logic [3:0]          BUS_BA;
	logic                BUS_REQ;
	logic                BUS_WAIT;
	logic                ILI;

	logic [31:0] rng_state;
	logic [15:0] prog [PROG_MAX];
	int          prog_len;
	logic        prog_ready;
	logic [31:0] model_r [16];
	logic        model_t;
	int          model_ili;
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	logic [3:0]  exp_ba [$];
	int          exp_stores;
	int          stores_seen;
	int          ili_seen;

	sh_core DUT (
		.CLK(CLK), .RST_N(RST_N), .CE(CE),
		.BUS_A(BUS_A), .BUS_DI(BUS_DI), .BUS_DO(BUS_DO), .BUS_WR(BUS_WR),
		.BUS_BA(BUS_BA), .BUS_REQ(BUS_REQ), .BUS_WAIT(BUS_WAIT), .ILI(ILI)
	);

	initial begin
		CLK = 1'b0;
		forever begin
			#CLK_HALF CLK = ~CLK;
		end
	end

	function automatic logic [31:0] next_rand();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	function automatic int rand_below(input int n);
		logic [31:0] r;
		r = next_rand();
		return int'({8'h00, r[31:8]}) % n;
	endfunction

	function automatic logic [3:0] pick_reg(input int avoid);
		logic [3:0] r;
		r = 4'(rand_below(16));
		if (int'(r) == avoid) begin
			r = r + 4'd1;
		end
		return r;
	endfunction

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("Checks failed");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			fail_run($sformatf("** Error at %0t: %s is %h, expected %h", $time, name, got, exp));
		end
	endtask

	// ****************************************
	// Program generator and reference model
	// ****************************************

	// Writes Rn with a random ALU operation
	function automatic logic [15:0] alu_instr(input logic [3:0] dst);
		logic [3:0] m;
		logic [7:0] imm;
		m   = 4'(rand_below(16));
		imm = 8'(rand_below(256));
		case (rand_below(10))
			0: return {4'h6, dst, m, 4'h3};
			1: return {4'hE, dst, imm};
			2: return {4'h3, dst, m, 4'hC};
			3: return {4'h7, dst, imm};
			4: return {4'h3, dst, m, 4'h8};
			5: return {4'h2, dst, m, 4'h9};
			6: return {4'h2, dst, m, 4'hB};
			7: return {4'h2, dst, m, 4'hA};
			8: return {4'h4, dst, 8'h00};
			default: return {4'h4, dst, 8'h01};
		endcase
	endfunction

	function automatic logic [15:0] random_instr(input int avoid);
		logic [3:0] n;
		logic [3:0] m;
		logic [3:0] op;
		int         pick;
		n    = pick_reg(avoid);
		m    = 4'(rand_below(16));
		pick = rand_below(100);
		if (pick < 15) begin
			// Opcodes 8 to F other than E lie outside the subset
			op = {1'b1, 3'(rand_below(8))};
			if (op == 4'hE) begin
				op = 4'hF;
			end
			return {op, 12'(next_rand() >> 8)};
		end else if (pick < 25) begin
			return `SH_NOP_IR;
		end else if (pick < 35) begin
			return {4'h3, n, m, 4'h0};
		end else if (pick < 40) begin
			return {4'h0, n, 4'h2, 4'h9};
		end else if (pick < 55) begin
			return {4'h2, n, m, 4'(rand_below(3))};
		end else begin
			return alu_instr(n);
		end
	endfunction

	// Lane 3 carries the lowest byte address
	task automatic expect_store(input logic [31:0] addr, input logic [31:0] data,
		input int size);
		int          nbytes;
		int          base;
		int          off;
		logic [31:0] lanes;
		logic [3:0]  ba;
		nbytes = 1 << size;
		base   = int'(addr[1:0]) / nbytes * nbytes;
		for (int l = 0; l < 4; l++) begin
			off             = 3 - l;
			ba[l]           = (off >= base) && (off < base + nbytes);
			lanes[l*8 +: 8] = 8'(data >> (8 * (nbytes - 1 - off % nbytes)));
		end
		exp_addr.push_back(addr);
		exp_data.push_back(lanes);
		exp_ba.push_back(ba);
		exp_stores++;
	endtask

	task automatic model_step(input logic [15:0] ir);
		logic [3:0]  n;
		logic [3:0]  m;
		logic [31:0] imm;
		n   = ir[11:8];
		m   = ir[7:4];
		imm = {{24{ir[7]}}, ir[7:0]};
		casez (ir)
			16'h0009: begin
			end
			16'h0?29: model_r[n] = {31'd0, model_t};
			16'h6??3: model_r[n] = model_r[m];
			16'hE???: model_r[n] = imm;
			16'h3??C: model_r[n] = model_r[n] + model_r[m];
			16'h7???: model_r[n] = model_r[n] + imm;
			16'h3??8: model_r[n] = model_r[n] - model_r[m];
			16'h2??9: model_r[n] = model_r[n] & model_r[m];
			16'h2??A: model_r[n] = model_r[n] ^ model_r[m];
			16'h2??B: model_r[n] = model_r[n] | model_r[m];
			16'h3??0: model_t = (model_r[n] == model_r[m]);
			16'h4?00: begin
				model_t    = model_r[n][31];
				model_r[n] = model_r[n] << 1;
			end
			16'h4?01: begin
				model_t    = model_r[n][0];
				model_r[n] = model_r[n] >> 1;
			end
			16'h2??0: expect_store(model_r[n], model_r[m], 0);
			16'h2??1: expect_store(model_r[n], model_r[m], 1);
			16'h2??2: expect_store(model_r[n], model_r[m], 2);
			default: model_ili++;
		endcase
	endtask

	task automatic emit(input logic [15:0] ir);
		prog[8'(prog_len)] = ir;
		prog_len++;
		model_step(ir);
	endtask

	task automatic build_program();
		logic [3:0] dst;
		logic [3:0] other;
		int         gap;
		prog_len = 0;
		for (int i = 0; i < 16; i++) begin
			emit({4'hE, 4'(i), 8'(rand_below(256))});
		end
		while (prog_len < BODY_LEN) begin
			dst   = 4'(rand_below(16));
			other = pick_reg(int'(dst));
			case (rand_below(4))
				0, 1: begin
					// A producer and then a store that uses it 1 to 3 slots later
					emit(alu_instr(dst));
					gap = rand_below(3);
					for (int g = 0; g < gap; g++) begin
						emit(random_instr(int'(dst)));
					end
					if (rand_below(2) == 0) begin
						emit({4'h2, other, dst, 4'(rand_below(3))});
					end else begin
						emit({4'h2, dst, other, 4'(rand_below(3))});
					end
				end
				2: begin
					case (rand_below(4))
						0: emit({4'h3, dst, dst, 4'h0});
						1: emit({4'h3, dst, other, 4'h0});
						2: emit({4'h4, dst, 8'h00});
						default: emit({4'h4, dst, 8'h01});
					endcase
					emit({4'h0, other, 8'h29});
					emit({4'h2, pick_reg(int'(other)), other, 4'h2});
				end
				default: emit(random_instr(-1));
			endcase
		end
		// Dump every register
		for (int i = 0; i < 16; i++) begin
			emit({4'h2, 4'((i + 1) % 16), 4'(i), 4'h2});
		end
	endtask

	// ****************************************
	// Bus model and stimulus
	// ****************************************
	function automatic logic [31:0] fetch_word(input logic [31:0] addr);
		logic [31:0] idx;
		logic [15:0] hi;
		logic [15:0] lo;
		idx = {1'b0, addr[31:2], 1'b0};
		hi  = `SH_NOP_IR;
		lo  = `SH_NOP_IR;
		if (idx < 32'(prog_len)) begin
			hi = prog[idx[7:0]];
		end
		if (idx + 32'd1 < 32'(prog_len)) begin
			lo = prog[idx[7:0] + 8'd1];
		end
		return {hi, lo};
	endfunction

	// Junk data outside fetch cycles
	always @(posedge CLK) begin
		#DRIVE_DLY;
		CE       = (rand_below(100) >= 15);
		BUS_WAIT = (rand_below(100) < 30);
		BUS_DI   = (BUS_REQ && !BUS_WR) ? fetch_word(BUS_A) : next_rand();
	end

	// ****************************************
	// Checks
	// ****************************************
	task automatic match_store();
		logic [31:0] mask;
		logic [3:0]  ba;
		if (exp_addr.size() == 0) begin
			fail_run("A store appeared on the bus after the last expected store");
		end else begin
			ba   = exp_ba[0];
			mask = {{8{ba[3]}}, {8{ba[2]}}, {8{ba[1]}}, {8{ba[0]}}};
			check_value("BUS_A", BUS_A, exp_addr[0]);
			check_value("BUS_BA", {28'd0, BUS_BA}, {28'd0, ba});
			check_value("BUS_DO", BUS_DO & mask, exp_data[0] & mask);
			void'(exp_addr.pop_front());
			void'(exp_data.pop_front());
			void'(exp_ba.pop_front());
			stores_seen++;
		end
	endtask

	// Values settle before the falling edge and hold until the next rising edge
	always @(negedge CLK) begin
		if (RST_N) begin
			if (ILI) begin
				ili_seen++;
			end
			if (BUS_WR) begin
				check_value("BUS_REQ", {31'd0, BUS_REQ}, 32'd1);
				if (CE && !BUS_WAIT) begin
					match_store();
				end
			end
		end
	end

	initial begin
		wait (prog_ready);
		repeat (prog_len * CYC_PER_IR) @(posedge CLK);
		fail_run($sformatf("Timeout: the program did not finish within %0d cycles",
			prog_len * CYC_PER_IR));
	end

	initial begin
		RST_N       = 1'b0;
		CE          = 1'b1;
		BUS_WAIT    = 1'b0;
		BUS_DI      = '0;
		rng_state   = 32'h826996d6;
		prog_ready  = 1'b0;
		model_r     = '{default: '0};
		model_t     = 1'b0;
		model_ili   = 0;
		exp_stores  = 0;
		stores_seen = 0;
		ili_seen    = 0;
		build_program();
		prog_ready = 1'b1;

		repeat (9) @(posedge CLK);
		@(negedge CLK);
		check_value("BUS_WR", {31'd0, BUS_WR}, 32'd0);
		check_value("ILI", {31'd0, ILI}, 32'd0);
		check_value("BUS_A", BUS_A, 32'd0);
		@(posedge CLK);
		#DRIVE_DLY;
		RST_N = 1'b1;

		while (stores_seen < exp_stores) begin
			@(posedge CLK);
		end
		// Let the NOP tail run to catch stray stores
		repeat (20) @(posedge CLK);
		check_value("ILI pulse count", 32'(ili_seen), 32'(model_ili));
		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire
